// File: Makefile
VERILATOR := verilator
TOP       := renameStageTb
FILELIST  := project.f
FLAGS     := --binary --timing -j 0
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The result is taken from the log, not from the exit code of the model
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/renameStageTb.sv
// ****************************************
// Rename stage testbench
// Model starts once ready first rises;
// outputs are compared while ready is high
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "renameConsts.svh"

module renameStageTb;

    localparam int W = `RENAME_WIDTH;
    localparam int WATCHDOG_NS = (10 + 64 + 400) * 10 + 2000;

    logic               clk;
    logic               rst;
    logic               renValid     [W];
    logic               hasDst       [W];
    renamePkg::lRegNumT logSrcA      [W];
    renamePkg::lRegNumT logSrcB      [W];
    renamePkg::lRegNumT logDst       [W];
    renamePkg::iqPtrT   iqPtr        [W];
    logic               relValid     [W];
    renamePkg::pRegNumT relPReg      [W];
    logic               ready;
    renamePkg::pRegNumT phySrcA      [W];
    renamePkg::pRegNumT phySrcB      [W];
    renamePkg::pRegNumT phyPrevDst   [W];
    renamePkg::pRegNumT phyDst       [W];
    renamePkg::iqPtrT   srcIqPtrA    [W];
    renamePkg::iqPtrT   srcIqPtrB    [W];
    renamePkg::iqPtrT   prevDstIqPtr [W];

    // Reference state and the expected outputs of the current group
    renamePkg::mapEntryT shadowMap [`LREG_NUM];
    renamePkg::pRegNumT  freeQ [$];
    renamePkg::pRegNumT  prevQ [$];
    renamePkg::mapEntryT expA    [W];
    renamePkg::mapEntryT expB    [W];
    renamePkg::mapEntryT expPrev [W];
    renamePkg::pRegNumT  expDst  [W];
    logic                expReady;
    logic                modelUp;
    logic                accepted;
    int                  errors;
    int                  checks;
    int unsigned         lcgState;

    renameStage renameStage_i (
        .clk(clk), .rst(rst), .renValid(renValid), .hasDst(hasDst),
        .logSrcA(logSrcA), .logSrcB(logSrcB), .logDst(logDst), .iqPtr(iqPtr),
        .ready(ready), .phySrcA(phySrcA), .phySrcB(phySrcB), .phyPrevDst(phyPrevDst),
        .srcIqPtrA(srcIqPtrA), .srcIqPtrB(srcIqPtrB), .prevDstIqPtr(prevDstIqPtr),
        .phyDst(phyDst), .relValid(relValid), .relPReg(relPReg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return (lcgState >> 8);
    endfunction

    function automatic logic groupValid();
        logic any;
        any = 1'b0;
        for (int i = 0; i < W; i++) begin
            any = any || renValid[i];
        end
        return any;
    endfunction

    // Expected outputs from the shadow map and the head of the free queue
    function automatic void predictGroup();
        int k;
        k = 0;
        expReady = (freeQ.size() >= W);
        for (int i = 0; i < W; i++) begin
            expA[i]    = shadowMap[logSrcA[i]];
            expB[i]    = shadowMap[logSrcB[i]];
            expPrev[i] = shadowMap[logDst[i]];
            expDst[i]  = '0;
            for (int j = 0; j < i; j++) begin
                if (renValid[j] && hasDst[j]) begin
                    if (logSrcA[i] == logDst[j]) expA[i] = {expDst[j], iqPtr[j]};
                    if (logSrcB[i] == logDst[j]) expB[i] = {expDst[j], iqPtr[j]};
                    if (logDst[i] == logDst[j]) expPrev[i] = {expDst[j], iqPtr[j]};
                end
            end
            if (renValid[i] && hasDst[i] && k < freeQ.size()) begin
                expDst[i] = freeQ[k];
                k++;
            end
        end
    endfunction

    task automatic checkPReg(string name, renamePkg::pRegNumT exp,
                             renamePkg::pRegNumT act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkIqPtr(string name, renamePkg::iqPtrT exp, renamePkg::iqPtrT act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkReady(logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail at %0t: ready expected %0b, got %0b", $time, exp, act);
        end
    endtask

    // Inputs settle 1 ns after the edge, so the falling edge sees stable outputs
    always @(negedge clk) begin
        if (modelUp) begin
            predictGroup();
            checkReady(expReady, ready);
            for (int i = 0; i < W; i++) begin
                if (expReady && renValid[i]) begin
                    checkPReg($sformatf("phySrcA[%0d]", i), expA[i].pReg, phySrcA[i]);
                    checkIqPtr($sformatf("srcIqPtrA[%0d]", i), expA[i].iqPtr, srcIqPtrA[i]);
                    checkPReg($sformatf("phySrcB[%0d]", i), expB[i].pReg, phySrcB[i]);
                    checkIqPtr($sformatf("srcIqPtrB[%0d]", i), expB[i].iqPtr, srcIqPtrB[i]);
                    if (hasDst[i]) begin
                        checkPReg($sformatf("phyDst[%0d]", i), expDst[i], phyDst[i]);
                        checkPReg($sformatf("phyPrevDst[%0d]", i), expPrev[i].pReg,
                                  phyPrevDst[i]);
                        checkIqPtr($sformatf("prevDstIqPtr[%0d]", i), expPrev[i].iqPtr,
                                   prevDstIqPtr[i]);
                    end
                end
            end
        end
    end

    // Pops and map writes of an accepted group, then releases in slot order
    always @(posedge clk) begin
        if (modelUp) begin
            accepted = expReady && groupValid();
            for (int i = 0; i < W; i++) begin
                if (accepted && renValid[i] && hasDst[i]) begin
                    shadowMap[logDst[i]] = {expDst[i], iqPtr[i]};
                    prevQ.push_back(expPrev[i].pReg);
                    void'(freeQ.pop_front());
                end
            end
            for (int i = 0; i < W; i++) begin
                if (relValid[i]) freeQ.push_back(relPReg[i]);
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #1;
        for (int i = 0; i < W; i++) begin
            relValid[i] = 1'b0;
        end
    endtask

    task automatic clearGroup();
        for (int i = 0; i < W; i++) begin
            renValid[i] = 1'b0;
            hasDst[i]   = 1'b0;
            logSrcA[i]  = '0;
            logSrcB[i]  = '0;
            logDst[i]   = '0;
            iqPtr[i]    = '0;
        end
    endtask

    task automatic setSlot(int s, logic dst, int a, int b, int d, int p);
        renValid[s] = 1'b1;
        hasDst[s]   = dst;
        logSrcA[s]  = renamePkg::lRegNumT'(a);
        logSrcB[s]  = renamePkg::lRegNumT'(b);
        logDst[s]   = renamePkg::lRegNumT'(d);
        iqPtr[s]    = renamePkg::iqPtrT'(p);
    endtask

    // Oldest pending previous registers go out first
    task automatic releaseSome(int n);
        for (int i = 0; i < W; i++) begin
            if (i < n && prevQ.size() > 0) begin
                relValid[i] = 1'b1;
                relPReg[i]  = prevQ.pop_front();
            end
        end
    endtask

    task automatic randomGroup(logic allDst);
        for (int i = 0; i < W; i++) begin
            setSlot(i, allDst || (nextRandom() % 2 == 1), nextRandom() % 32,
                    nextRandom() % 32, nextRandom() % 32, nextRandom() % 16);
            if (!allDst && nextRandom() % 4 == 0) renValid[i] = 1'b0;
        end
    endtask

    // Hold the group until accepted, feeding releases while it waits
    task automatic runGroup();
        int tries;
        tries = 0;
        tick();
        while (!accepted && groupValid() && tries < 40) begin
            releaseSome(W);
            tick();
            tries++;
        end
        if (!accepted && groupValid()) begin
            errors++;
            $display("Group held at %0t was never accepted", $time);
        end
        clearGroup();
    endtask

    task automatic readAllRegs();
        for (int g = 0; g < `LREG_NUM / 4; g++) begin
            setSlot(0, 1'b0, 4 * g, 4 * g + 1, 0, 0);
            setSlot(1, 1'b0, 4 * g + 2, 4 * g + 3, 0, 0);
            runGroup();
        end
    endtask

    initial begin
        int waitCycles;
        errors   = 0;
        checks   = 0;
        modelUp  = 1'b0;
        accepted = 1'b0;
        lcgState = 11687;
        rst      = 1'b1;
        clearGroup();
        for (int i = 0; i < W; i++) begin
            relValid[i] = 1'b0;
            relPReg[i]  = '0;
        end
        for (int l = 0; l < `LREG_NUM; l++) begin
            shadowMap[l] = {renamePkg::pRegNumT'(l + `FREE_LIST_NUM), renamePkg::iqPtrT'(0)};
        end
        for (int p = 0; p < `FREE_LIST_NUM; p++) begin
            freeQ.push_back(renamePkg::pRegNumT'(p));
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        waitCycles = 0;
        while (!ready && waitCycles < 64) begin
            tick();
            waitCycles++;
        end
        if (!ready) begin
            errors++;
            $display("Ready did not rise within 64 cycles after reset");
        end else begin
            modelUp = 1'b1;
            readAllRegs();
            // Allocation order from a fresh list
            repeat (6) begin
                randomGroup(1'b1);
                runGroup();
            end
            readAllRegs();
            // Bypass inside one group, with a shared destination
            setSlot(0, 1'b1, 3, 4, 7, 9);
            setSlot(1, 1'b1, 7, 7, 7, 12);
            runGroup();
            readAllRegs();
            // Refill the list, drain it, then hold a group while empty
            while (prevQ.size() > 0) begin
                releaseSome(W);
                tick();
            end
            repeat (16) begin
                randomGroup(1'b1);
                runGroup();
            end
            randomGroup(1'b1);
            repeat (4) tick();
            // Held group is withdrawn, so its destinations must keep their old entries
            clearGroup();
            releaseSome(W);
            tick();
            readAllRegs();
            // Recycling under random traffic
            repeat (150) begin
                randomGroup(1'b0);
                releaseSome(nextRandom() % 3);
                runGroup();
            end
            readAllRegs();
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/renamePkg.sv
rtl/multiPortRam.sv
rtl/renameMapTable.sv
rtl/freeList.sv
rtl/renameStage.sv
bench/renameStageTb.sv

// File: rtl/freeList.sv
// ****************************************
// Circular free list of physical registers
// Releases before the fill ends are lost;
// commit never frees more than it took
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "renameConsts.svh"

module freeList (
    input  logic               clk,
    input  logic               rst,
    input  logic               mapReady,
    input  logic               renValid [`RENAME_WIDTH],
    input  logic               hasDst   [`RENAME_WIDTH],
    input  logic               relValid [`RENAME_WIDTH],
    input  renamePkg::pRegNumT relPReg  [`RENAME_WIDTH],
    output renamePkg::pRegNumT phyDst   [`RENAME_WIDTH],
    output logic               ready,
    output logic               renAccept
);

    localparam int PTR_W = $clog2(`FREE_LIST_NUM);
    localparam int CNT_W = $clog2(`FREE_LIST_NUM + 1);

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] fillIdx;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] popCnt;
    logic [CNT_W-1:0] popTaken;
    logic [CNT_W-1:0] pushCnt;
    logic             fillDone;
    logic             anyValid;

    logic               ramWe [`RENAME_WIDTH];
    logic [PTR_W-1:0]   ramWa [`RENAME_WIDTH];
    renamePkg::pRegNumT ramWv [`RENAME_WIDTH];
    logic [PTR_W-1:0]   ramRa [`RENAME_WIDTH];
    renamePkg::pRegNumT ramRv [`RENAME_WIDTH];

    multiPortRam #(
        .entryT(renamePkg::pRegNumT),
        .ENTRY_NUM(`FREE_LIST_NUM),
        .READ_NUM(`RENAME_WIDTH),
        .WRITE_NUM(`RENAME_WIDTH)
    ) listRam (
        .clk(clk),
        .we(ramWe),
        .wa(ramWa),
        .wv(ramWv),
        .ra(ramRa),
        .rv(ramRv)
    );

    // A full group must always fit, whatever it actually needs
    assign ready = fillDone && mapReady && (count >= CNT_W'(`RENAME_WIDTH));

    // Pop side, destinations take consecutive head entries
    always_comb begin
        popCnt   = '0;
        anyValid = 1'b0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            ramRa[i]  = head + PTR_W'(popCnt);
            phyDst[i] = ramRv[i];
            anyValid  = anyValid || renValid[i];
            if (renValid[i] && hasDst[i]) begin
                popCnt = popCnt + 1'b1;
            end
        end
        renAccept = ready && anyValid;
        popTaken  = renAccept ? popCnt : '0;
    end

    // Push side, or the fill pattern until it is done
    always_comb begin
        pushCnt = '0;
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (fillDone) begin
                ramWe[i] = relValid[i];
                ramWa[i] = tail + PTR_W'(pushCnt);
                ramWv[i] = relPReg[i];
                if (relValid[i]) begin
                    pushCnt = pushCnt + 1'b1;
                end
            end else begin
                ramWe[i] = (i == 0);
                ramWa[i] = fillIdx;
                ramWv[i] = renamePkg::pRegNumT'(fillIdx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            fillIdx  <= '0;
            fillDone <= 1'b0;
        end else if (!fillDone) begin
            fillIdx <= fillIdx + 1'b1;
            // List is full, so tail wraps back onto head
            if (fillIdx == PTR_W'(`FREE_LIST_NUM - 1)) begin
                fillDone <= 1'b1;
                count    <= CNT_W'(`FREE_LIST_NUM);
            end
        end else begin
            head  <= head + PTR_W'(popTaken);
            tail  <= tail + PTR_W'(pushCnt);
            count <= count + pushCnt - popTaken;
        end
    end

endmodule

`default_nettype wire

// File: rtl/multiPortRam.sv
// ****************************************
// Distributed RAM, no reset on contents
// Reads are asynchronous; on a write
// collision the highest port wins
// ****************************************
`timescale 1ns/1ps
`default_nettype none

module multiPortRam #(
    parameter type entryT = logic,
    parameter int ENTRY_NUM = 32,
    parameter int READ_NUM = 2,
    parameter int WRITE_NUM = 2
) (
    input  logic                         clk,
    input  logic                         we [WRITE_NUM],
    input  logic [$clog2(ENTRY_NUM)-1:0] wa [WRITE_NUM],
    input  entryT                        wv [WRITE_NUM],
    input  logic [$clog2(ENTRY_NUM)-1:0] ra [READ_NUM],
    output entryT                        rv [READ_NUM]
);

    entryT mem [ENTRY_NUM];

    // Later ports are applied last and so take priority
    always_ff @(posedge clk) begin
        for (int i = 0; i < WRITE_NUM; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < READ_NUM; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

endmodule

`default_nettype wire

// File: rtl/renameConsts.svh
// ****************************************
// Sizing of the rename stage
// FREE_LIST_NUM and IQ_ENTRY_NUM must be
// powers of two, pointers wrap naturally
// ****************************************
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// Instructions renamed per group
`define RENAME_WIDTH 2

// Architectural and physical register counts
`define LREG_NUM 32
`define PREG_NUM 64

// Registers not mapped after reset start out free
`define FREE_LIST_NUM (`PREG_NUM - `LREG_NUM)

`define IQ_ENTRY_NUM 16

// Source A, source B and old destination per slot
`define MAP_READ_NUM (3 * `RENAME_WIDTH)

`endif

// File: rtl/renameMapTable.sv
// ****************************************
// Register map table and wakeup table
// Fill takes LREG_NUM cycles after reset;
// group writes are ignored until mapReady
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "renameConsts.svh"

module renameMapTable (
    input  logic               clk,
    input  logic               rst,
    input  logic               renAccept,
    input  logic               renValid     [`RENAME_WIDTH],
    input  logic               hasDst       [`RENAME_WIDTH],
    input  renamePkg::lRegNumT logSrcA      [`RENAME_WIDTH],
    input  renamePkg::lRegNumT logSrcB      [`RENAME_WIDTH],
    input  renamePkg::lRegNumT logDst       [`RENAME_WIDTH],
    input  renamePkg::iqPtrT   iqPtr        [`RENAME_WIDTH],
    input  renamePkg::pRegNumT phyDst       [`RENAME_WIDTH],
    output renamePkg::pRegNumT phySrcA      [`RENAME_WIDTH],
    output renamePkg::pRegNumT phySrcB      [`RENAME_WIDTH],
    output renamePkg::pRegNumT phyPrevDst   [`RENAME_WIDTH],
    output renamePkg::iqPtrT   srcIqPtrA    [`RENAME_WIDTH],
    output renamePkg::iqPtrT   srcIqPtrB    [`RENAME_WIDTH],
    output renamePkg::iqPtrT   prevDstIqPtr [`RENAME_WIDTH],
    output logic               mapReady
);

    // Read ports per slot
    localparam int OPS = `MAP_READ_NUM / `RENAME_WIDTH;

    renamePkg::lRegNumT  fillIdx;

    logic                ramWe [`RENAME_WIDTH];
    renamePkg::lRegNumT  ramWa [`RENAME_WIDTH];
    renamePkg::mapEntryT ramWv [`RENAME_WIDTH];
    renamePkg::lRegNumT  ramRa [`MAP_READ_NUM];
    renamePkg::mapEntryT ramRv [`MAP_READ_NUM];

    multiPortRam #(
        .entryT(renamePkg::mapEntryT),
        .ENTRY_NUM(`LREG_NUM),
        .READ_NUM(`MAP_READ_NUM),
        .WRITE_NUM(`RENAME_WIDTH)
    ) mapRam (
        .clk(clk),
        .we(ramWe),
        .wa(ramWa),
        .wv(ramWv),
        .ra(ramRa),
        .rv(ramRv)
    );

    // Fill walks every logical register once, then stops on the wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            fillIdx  <= '0;
            mapReady <= 1'b0;
        end else if (!mapReady) begin
            fillIdx <= fillIdx + 1'b1;
            if (fillIdx == renamePkg::lRegNumT'(`LREG_NUM - 1)) begin
                mapReady <= 1'b1;
            end
        end
    end

    // Write side
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            if (mapReady) begin
                ramWe[i]       = renAccept && renValid[i] && hasDst[i];
                ramWa[i]       = logDst[i];
                ramWv[i].pReg  = phyDst[i];
                ramWv[i].iqPtr = iqPtr[i];
            end else begin
                // L maps above the registers held by the free list
                ramWe[i]       = (i == 0);
                ramWa[i]       = fillIdx;
                ramWv[i].pReg  = renamePkg::pRegNumT'(fillIdx) +
                                 renamePkg::pRegNumT'(`FREE_LIST_NUM);
                ramWv[i].iqPtr = '0;
            end
        end
    end

    // Read addresses
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            ramRa[OPS*i]     = logSrcA[i];
            ramRa[OPS*i + 1] = logSrcB[i];
            ramRa[OPS*i + 2] = logDst[i];
        end
    end

    // Table values, then bypass from older slots in the same group
    always_comb begin
        for (int i = 0; i < `RENAME_WIDTH; i++) begin
            phySrcA[i]      = ramRv[OPS*i].pReg;
            srcIqPtrA[i]    = ramRv[OPS*i].iqPtr;
            phySrcB[i]      = ramRv[OPS*i + 1].pReg;
            srcIqPtrB[i]    = ramRv[OPS*i + 1].iqPtr;
            phyPrevDst[i]   = ramRv[OPS*i + 2].pReg;
            prevDstIqPtr[i] = ramRv[OPS*i + 2].iqPtr;

            // Youngest older producer is applied last
            for (int j = 0; j < i; j++) begin
                if (renValid[j] && hasDst[j]) begin
                    if (logSrcA[i] == logDst[j]) begin
                        phySrcA[i]   = phyDst[j];
                        srcIqPtrA[i] = iqPtr[j];
                    end
                    if (logSrcB[i] == logDst[j]) begin
                        phySrcB[i]   = phyDst[j];
                        srcIqPtrB[i] = iqPtr[j];
                    end
                    // Same destination: previous mapping is the older slot's
                    if (logDst[i] == logDst[j]) begin
                        phyPrevDst[i]   = phyDst[j];
                        prevDstIqPtr[i] = iqPtr[j];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/renamePkg.sv
// ****************************************
// Register number and map entry types
// Widths follow renameConsts.svh
// ****************************************
`default_nettype none

`include "renameConsts.svh"

package renamePkg;

    // Logical register number
    typedef logic [$clog2(`LREG_NUM)-1:0] lRegNumT;

    // Physical register number
    typedef logic [$clog2(`PREG_NUM)-1:0] pRegNumT;

    // Issue-queue entry of the producer
    typedef logic [$clog2(`IQ_ENTRY_NUM)-1:0] iqPtrT;

    // One map table line, also the wakeup pointer
    typedef struct packed {
        pRegNumT pReg;
        iqPtrT   iqPtr;
    } mapEntryT;

endpackage

`default_nettype wire

// File: rtl/renameStage.sv
// ****************************************
// Rename stage top level
// Outputs are combinational; a group is
// taken at an edge where ready is high
// ****************************************
`timescale 1ns/1ps
`default_nettype none

`include "renameConsts.svh"

module renameStage (
    input  logic               clk,
    input  logic               rst,

    // Rename group
    input  logic               renValid     [`RENAME_WIDTH],
    input  logic               hasDst       [`RENAME_WIDTH],
    input  renamePkg::lRegNumT logSrcA      [`RENAME_WIDTH],
    input  renamePkg::lRegNumT logSrcB      [`RENAME_WIDTH],
    input  renamePkg::lRegNumT logDst       [`RENAME_WIDTH],
    input  renamePkg::iqPtrT   iqPtr        [`RENAME_WIDTH],
    output logic               ready,

    // Rename results
    output renamePkg::pRegNumT phySrcA      [`RENAME_WIDTH],
    output renamePkg::pRegNumT phySrcB      [`RENAME_WIDTH],
    output renamePkg::pRegNumT phyPrevDst   [`RENAME_WIDTH],
    output renamePkg::iqPtrT   srcIqPtrA    [`RENAME_WIDTH],
    output renamePkg::iqPtrT   srcIqPtrB    [`RENAME_WIDTH],
    output renamePkg::iqPtrT   prevDstIqPtr [`RENAME_WIDTH],
    output renamePkg::pRegNumT phyDst       [`RENAME_WIDTH],

    // Commit release
    input  logic               relValid     [`RENAME_WIDTH],
    input  renamePkg::pRegNumT relPReg      [`RENAME_WIDTH]
);

    logic renAccept;
    logic mapReady;

    renameMapTable mapTable_i (
        .clk(clk),
        .rst(rst),
        .renAccept(renAccept),
        .renValid(renValid),
        .hasDst(hasDst),
        .logSrcA(logSrcA),
        .logSrcB(logSrcB),
        .logDst(logDst),
        .iqPtr(iqPtr),
        .phyDst(phyDst),
        .phySrcA(phySrcA),
        .phySrcB(phySrcB),
        .phyPrevDst(phyPrevDst),
        .srcIqPtrA(srcIqPtrA),
        .srcIqPtrB(srcIqPtrB),
        .prevDstIqPtr(prevDstIqPtr),
        .mapReady(mapReady)
    );

    freeList freeList_i (
        .clk(clk),
        .rst(rst),
        .mapReady(mapReady),
        .renValid(renValid),
        .hasDst(hasDst),
        .relValid(relValid),
        .relPReg(relPReg),
        .phyDst(phyDst),
        .ready(ready),
        .renAccept(renAccept)
    );

endmodule

`default_nettype wire
